//--- hdl/soc_pkg.sv
/* Types and constants shared by the SoC bus core: PI1 links, the word address map
   and the reset codes. Compiled ahead of every RTL file that imports it. */
package soc_pkg;

	localparam int ARCH_W = 32;
	localparam int SEL_W  = ARCH_W / 8;
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W);

	typedef enum logic [1:0] {
		PI1_NONE = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RW   = 2'b11
	} pi1_op_e;

	// Master to slave
	typedef struct packed {
		pi1_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0]  sel;
	} pi1_req_t;

	// Slave to master, data valid while rdy is high
	typedef struct packed {
		logic [ARCH_W-1:0] data;
		logic              rdy;
	} pi1_rsp_t;

	// Word address map
	localparam logic [ADDR_W-1:0] DEVTBL_BASE  = 'h000;
	localparam int                DEVTBL_WORDS = 16;
	localparam logic [ADDR_W-1:0] RAM_BASE     = 'h400;

	localparam logic [ADDR_W-1:0] DT_DEVCOUNT = 'd0;
	localparam logic [ADDR_W-1:0] DT_RAMSZ    = 'd1;
	localparam logic [ADDR_W-1:0] DT_CLKFREQ  = 'd2;
	localparam logic [ADDR_W-1:0] DT_RSTCTL   = 'd3;
	localparam logic [ADDR_W-1:0] DT_RSTCAUSE = 'd4;

	// Two reset request lines packed as {rst0, rst1}
	typedef enum logic [1:0] {
		RST_NONE     = 2'b00,
		RST_WARM     = 2'b01,
		RST_POWEROFF = 2'b10,
		RST_COLD     = 2'b11
	} rst_cmd_e;

	typedef enum logic [1:0] {
		CAUSE_POWERON = 2'd0,
		CAUSE_WARM    = 2'd1,
		CAUSE_COLD    = 2'd2
	} rst_cause_e;

endpackage

//--- hdl/rst_sequencer.sv
/* Reset sequencer: stretches the external reset and the software reset commands
   into the system reset, and keeps the cause of the last reset for software. */
`timescale 1ns/10ps

module rst_sequencer #(
	parameter int RST_CNT_W = 16
) (
	input  logic                clk_w,
	input  logic                rst_p,
	input  soc_pkg::rst_cmd_e   rst_cmd_i,
	output logic                sys_rst_o,
	output soc_pkg::rst_cause_e rst_cause_o
);
	import soc_pkg::*;

	logic [RST_CNT_W-1:0] cnt_q;
	logic                 pwroff_q;
	rst_cause_e           cause_q;
	logic                 sw_rst;

	assign sw_rst = (rst_cmd_i == RST_WARM) || (rst_cmd_i == RST_COLD);

	// Reload on any reset source, run down once all of them are gone
	always_ff @(posedge clk_w) begin
		if (rst_p || sw_rst || pwroff_q) begin
			cnt_q <= '1;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Power-off is sticky, only the external reset clears it
	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (rst_cmd_i == RST_POWEROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	// Not cleared by sys_rst, so it outlives the reset it describes
	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			cause_q <= CAUSE_POWERON;
		end else if (rst_cmd_i == RST_WARM) begin
			cause_q <= CAUSE_WARM;
		end else if (rst_cmd_i == RST_COLD) begin
			cause_q <= CAUSE_COLD;
		end
	end

	assign sys_rst_o   = pwroff_q || (cnt_q != '0);
	assign rst_cause_o = cause_q;

endmodule

//--- hdl/pi1_router.sv
/* PI1 router for a single master: decodes the word address, forwards one transfer
   at a time to the device table or the scratch RAM, and answers unmapped accesses. */
`timescale 1ns/10ps

module pi1_router #(
	parameter int RAM_WORDS = 256
) (
	input  logic              clk_w,
	input  logic              sys_rst_i,
	input  soc_pkg::pi1_req_t m_req_i,
	output soc_pkg::pi1_rsp_t m_rsp_o,
	output soc_pkg::pi1_req_t devtbl_req_o,
	input  soc_pkg::pi1_rsp_t devtbl_rsp_i,
	output soc_pkg::pi1_req_t ram_req_o,
	input  soc_pkg::pi1_rsp_t ram_rsp_i
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FWD,
		ST_RESP
	} state_e;

	typedef enum logic {
		TGT_DEVTBL,
		TGT_RAM
	} target_e;

	localparam logic [ADDR_W-1:0] DEVTBL_SPAN = ADDR_W'(DEVTBL_WORDS);
	localparam logic [ADDR_W-1:0] RAM_SPAN    = ADDR_W'(RAM_WORDS);

	state_e            state_q;
	target_e           tgt_q;
	pi1_req_t          fwd_q;
	logic [ARCH_W-1:0] rdata_q;

	logic [ADDR_W-1:0] dev_off;
	logic [ADDR_W-1:0] ram_off;
	logic              hit_devtbl;
	logic              hit_ram;
	pi1_req_t          fwd_d;
	pi1_rsp_t          slv_rsp;

	// Below the base the offset wraps, so one unsigned compare checks both ends
	assign dev_off    = m_req_i.addr - DEVTBL_BASE;
	assign ram_off    = m_req_i.addr - RAM_BASE;
	assign hit_devtbl = dev_off < DEVTBL_SPAN;
	assign hit_ram    = ram_off < RAM_SPAN;

	// Slaves see the offset within their own window
	always_comb begin
		fwd_d      = m_req_i;
		fwd_d.addr = hit_ram ? ram_off : dev_off;
	end

	assign slv_rsp = (tgt_q == TGT_RAM) ? ram_rsp_i : devtbl_rsp_i;

	always_ff @(posedge clk_w) begin
		if (sys_rst_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (m_req_i.op != PI1_NONE) begin
						// Unmapped goes straight to the response
						state_q <= (hit_devtbl || hit_ram) ? ST_FWD : ST_RESP;
					end
				end
				ST_FWD: begin
					if (slv_rsp.rdy) begin
						state_q <= ST_RESP;
					end
				end
				ST_RESP: begin
					state_q <= ST_IDLE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Request, target and read data only matter while the FSM is busy
	always_ff @(posedge clk_w) begin
		if (state_q == ST_IDLE) begin
			fwd_q   <= fwd_d;
			tgt_q   <= hit_ram ? TGT_RAM : TGT_DEVTBL;
			rdata_q <= '0;
		end else if (state_q == ST_FWD && slv_rsp.rdy) begin
			rdata_q <= slv_rsp.data;
		end
	end

	always_comb begin
		devtbl_req_o = fwd_q;
		ram_req_o    = fwd_q;
		if (state_q != ST_FWD || tgt_q != TGT_DEVTBL) begin
			devtbl_req_o.op = PI1_NONE;
		end
		if (state_q != ST_FWD || tgt_q != TGT_RAM) begin
			ram_req_o.op = PI1_NONE;
		end
	end

	assign m_rsp_o.data = rdata_q;
	assign m_rsp_o.rdy  = (state_q == ST_RESP);

endmodule

//--- hdl/dev_table.sv
/* Device table slave: read-only words describing the system, the reset cause,
   and a control word whose writes become software reset commands. */
`timescale 1ns/10ps

module dev_table #(
	parameter int RAM_WORDS = 256,
	parameter int CLK_FREQ  = 50000000
) (
	input  logic                clk_w,
	input  logic                sys_rst_i,
	input  soc_pkg::pi1_req_t   req_i,
	output soc_pkg::pi1_rsp_t   rsp_o,
	input  soc_pkg::rst_cause_e rst_cause_i,
	output soc_pkg::rst_cmd_e   rst_cmd_o
);
	import soc_pkg::*;

	// Slaves behind the router
	localparam int DEV_COUNT = 2;

	logic              rdy_q;
	logic [ARCH_W-1:0] rdata_q;
	rst_cmd_e          cmd_q;

	logic              access;
	logic              wr_en;
	logic [ARCH_W-1:0] rdata;

	// rdy_q blocks a second access while the master still holds the op
	assign access = (req_i.op != PI1_NONE) && !rdy_q;
	assign wr_en  = access && (req_i.op == PI1_WR || req_i.op == PI1_RW);

	always_comb begin
		case (req_i.addr)
			DT_DEVCOUNT: rdata = ARCH_W'(DEV_COUNT);
			DT_RAMSZ:    rdata = ARCH_W'(RAM_WORDS * SEL_W);
			DT_CLKFREQ:  rdata = ARCH_W'(CLK_FREQ);
			DT_RSTCTL:   rdata = '0;
			DT_RSTCAUSE: rdata = ARCH_W'(rst_cause_i);
			default:     rdata = '0;
		endcase
	end

	always_ff @(posedge clk_w) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			cmd_q <= RST_NONE;
		end else begin
			rdy_q <= access;
			cmd_q <= RST_NONE;
			// Command is a single-cycle pulse, low byte lane only
			if (wr_en && req_i.addr == DT_RSTCTL && req_i.sel[0]) begin
				cmd_q <= rst_cmd_e'(req_i.data[1:0]);
			end
		end
	end

	always_ff @(posedge clk_w) begin
		if (access) begin
			rdata_q <= rdata;
		end
	end

	assign rsp_o.data = rdata_q;
	assign rsp_o.rdy  = rdy_q;
	assign rst_cmd_o  = cmd_q;

endmodule

//--- hdl/scratch_ram.sv
/* Scratch RAM slave: word array with byte-select writes, reads and swaps.
   Contents are kept across software resets. */
`timescale 1ns/10ps

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic              clk_w,
	input  logic              sys_rst_i,
	input  soc_pkg::pi1_req_t req_i,
	output soc_pkg::pi1_rsp_t rsp_o
);
	import soc_pkg::*;

	// Depth is a power of two, so the low bits give the offset modulo RAM_WORDS
	localparam int IDX_W = $clog2(RAM_WORDS);

	logic [ARCH_W-1:0] mem [RAM_WORDS];
	logic              rdy_q;
	logic [ARCH_W-1:0] rdata_q;

	logic [IDX_W-1:0]  idx;
	logic              access;
	logic              wr_en;

	assign idx    = req_i.addr[IDX_W-1:0];
	assign access = (req_i.op != PI1_NONE) && !rdy_q;
	assign wr_en  = access && (req_i.op == PI1_WR || req_i.op == PI1_RW);

	always_ff @(posedge clk_w) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= access;
		end
	end

	// Read returns the old word, so a swap gets the value before its own write
	always_ff @(posedge clk_w) begin
		if (access) begin
			rdata_q <= mem[idx];
		end
		for (int b = 0; b < SEL_W; b++) begin
			if (wr_en && req_i.sel[b]) begin
				mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
			end
		end
	end

	assign rsp_o.data = rdata_q;
	assign rsp_o.rdy  = rdy_q;

endmodule

//--- hdl/soc_top.sv
/* Bus and reset core of the board top: one external PI1 master, the router,
   the device table, the scratch RAM and the reset sequencer. */
`timescale 1ns/10ps

module soc_top #(
	parameter int RST_CNT_W = 16,
	parameter int RAM_WORDS = 256,
	parameter int CLK_FREQ  = 50000000
) (
	input  logic              clk_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t m_req_i,
	output soc_pkg::pi1_rsp_t m_rsp_o,
	output logic              sys_rst_o
);
	import soc_pkg::*;

	logic       sys_rst;
	rst_cmd_e   rst_cmd;
	rst_cause_e rst_cause;
	pi1_req_t   devtbl_req;
	pi1_rsp_t   devtbl_rsp;
	pi1_req_t   ram_req;
	pi1_rsp_t   ram_rsp;

	assign sys_rst_o = sys_rst;

	rst_sequencer #(
		.RST_CNT_W (RST_CNT_W)
	) u_rst_sequencer (
		.clk_w       (clk_w),
		.rst_p       (rst_p),
		.rst_cmd_i   (rst_cmd),
		.sys_rst_o   (sys_rst),
		.rst_cause_o (rst_cause)
	);

	pi1_router #(
		.RAM_WORDS (RAM_WORDS)
	) u_pi1_router (
		.clk_w        (clk_w),
		.sys_rst_i    (sys_rst),
		.m_req_i      (m_req_i),
		.m_rsp_o      (m_rsp_o),
		.devtbl_req_o (devtbl_req),
		.devtbl_rsp_i (devtbl_rsp),
		.ram_req_o    (ram_req),
		.ram_rsp_i    (ram_rsp)
	);

	dev_table #(
		.RAM_WORDS (RAM_WORDS),
		.CLK_FREQ  (CLK_FREQ)
	) u_dev_table (
		.clk_w       (clk_w),
		.sys_rst_i   (sys_rst),
		.req_i       (devtbl_req),
		.rsp_o       (devtbl_rsp),
		.rst_cause_i (rst_cause),
		.rst_cmd_o   (rst_cmd)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_scratch_ram (
		.clk_w     (clk_w),
		.sys_rst_i (sys_rst),
		.req_i     (ram_req),
		.rsp_o     (ram_rsp)
	);

endmodule

//--- verification/soc_tb.sv
/* Testbench for the SoC bus and reset core. It applies a table of PI1 transfers and
   reset actions to soc_top and checks the read data against a reference model. */
`timescale 1ns/10ps

module soc_tb;
	import soc_pkg::*;

	localparam int RAM_WORDS  = 64;
	localparam int TRANS_WAIT = 10;
	localparam int RST_WAIT   = 20;
	localparam logic [ADDR_W-1:0] UNMAPPED = 'h300;

	typedef enum logic [1:0] {
		ACT_NONE,
		ACT_EXPECT_RST,
		ACT_PULSE_RST
	} action_e;

	typedef struct packed {
		pi1_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] wdata;
		logic [SEL_W-1:0]  sel;
		logic [ARCH_W-1:0] exp;
		logic              chk;
		action_e           act;
	} stim_t;

	logic     clk_w;
	logic     rst_p;
	pi1_req_t m_req;
	pi1_rsp_t m_rsp;
	logic     sys_rst;

	stim_t             stim_q[$];
	logic [ARCH_W-1:0] ram_model [RAM_WORDS];
	logic [31:0]       lcg_state;
	int                err_cnt = 0;
	int                fail_cnt = 0;
	int                cycle_cnt = 0;
	int                cycle_limit = 0;

	soc_top #(
		.RST_CNT_W (4),
		.RAM_WORDS (RAM_WORDS),
		.CLK_FREQ  (250000000)
	) dut (
		.clk_w     (clk_w),
		.rst_p     (rst_p),
		.m_req_i   (m_req),
		.m_rsp_o   (m_rsp),
		.sys_rst_o (sys_rst)
	);

	initial begin
		clk_w = 1'b0;
		forever #2 clk_w = ~clk_w;
	end

	always @(posedge clk_w) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// New bytes replace the old ones only where sel is set
	function automatic logic [ARCH_W-1:0] merge_bytes(input logic [ARCH_W-1:0] old_w,
			input logic [ARCH_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [ARCH_W-1:0] w;
		w = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				w[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return w;
	endfunction

	function automatic pi1_req_t probe_req();
		pi1_req_t r;
		r = '0;
		r.op = PI1_RD;
		r.addr = DT_DEVCOUNT;
		r.sel = 4'hf;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [ARCH_W-1:0] got,
			input logic [ARCH_W-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic push_entry(input pi1_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [ARCH_W-1:0] wdata, input logic [SEL_W-1:0] sel,
			input logic [ARCH_W-1:0] exp, input logic chk, input action_e act);
		stim_q.push_back(stim_t'{op, addr, wdata, sel, exp, chk, act});
	endtask

	// Holds the request until rdy and then returns the bus to idle
	task automatic do_transfer(input pi1_req_t req, output logic [ARCH_W-1:0] rdata,
			output logic ok);
		int n;
		n = 0;
		ok = 1'b0;
		rdata = '0;
		m_req = req;
		while (!ok && n < TRANS_WAIT) begin
			@(posedge clk_w);
			#1;
			n++;
			if (m_rsp.rdy === 1'b1) begin
				ok = 1'b1;
				rdata = m_rsp.data;
			end
		end
		m_req = '0;
		if (!ok) begin
			fail_cnt++;
			$display("No rdy within %0d cycles for op %0d at word 0x%0h",
				TRANS_WAIT, req.op, req.addr);
		end
	endtask

	// A read stays pending the whole time and none may complete in reset
	task automatic hold_in_reset(input int cycles);
		m_req = probe_req();
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_w);
			#1;
			check_value("sys_rst_o", 32'(sys_rst), 32'd1);
			check_value("m_rsp_o.rdy", 32'(m_rsp.rdy), 32'd0);
		end
	endtask

	task automatic expect_reset_rise();
		int n;
		n = 0;
		m_req = probe_req();
		do begin
			@(posedge clk_w);
			#1;
			n++;
		end while (sys_rst !== 1'b1 && n < 4);
		if (sys_rst !== 1'b1) begin
			fail_cnt++;
			$display("System reset did not rise after the reset command");
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		m_req = probe_req();
		while (sys_rst !== 1'b0 && n < RST_WAIT) begin
			check_value("m_rsp_o.rdy", 32'(m_rsp.rdy), 32'd0);
			@(posedge clk_w);
			#1;
			n++;
		end
		m_req = '0;
		if (sys_rst !== 1'b0) begin
			fail_cnt++;
			$display("System reset still high %0d cycles after its release", RST_WAIT);
		end
	endtask

	task automatic build_table();
		// Device table, then the unmapped window and the default slave
		push_entry(PI1_RD, DT_DEVCOUNT, 0, 4'hf, 32'd2, 1'b1, ACT_NONE);
		push_entry(PI1_RD, DT_RAMSZ, 0, 4'hf, 32'(RAM_WORDS * 4), 1'b1, ACT_NONE);
		push_entry(PI1_RD, DT_CLKFREQ, 0, 4'hf, 32'd250000000, 1'b1, ACT_NONE);
		push_entry(PI1_RD, DT_RSTCAUSE, 0, 4'hf, 32'(CAUSE_POWERON), 1'b1, ACT_NONE);
		push_entry(PI1_RD, DT_RSTCTL, 0, 4'hf, 32'h0, 1'b1, ACT_NONE);
		push_entry(PI1_WR, DT_DEVCOUNT, 32'h5, 4'hf, 32'h0, 1'b0, ACT_NONE);
		push_entry(PI1_RD, DT_DEVCOUNT, 0, 4'hf, 32'd2, 1'b1, ACT_NONE);
		push_entry(PI1_RD, UNMAPPED, 0, 4'hf, 32'h0, 1'b1, ACT_NONE);
		push_entry(PI1_WR, UNMAPPED, 32'hdead_beef, 4'hf, 32'h0, 1'b0, ACT_NONE);
		push_entry(PI1_RW, UNMAPPED, 32'h1234_5678, 4'hf, 32'h0, 1'b1, ACT_NONE);
		push_entry(PI1_RD, UNMAPPED, 0, 4'hf, 32'h0, 1'b1, ACT_NONE);
		// RAM fill, partial writes, read back and swaps
		for (int k = 0; k < 8; k++) begin
			push_entry(PI1_WR, ADDR_W'(RAM_BASE + k), 0, 4'hf, 0, 1'b0, ACT_NONE);
		end
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 63), 0, 4'hf, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 0), 0, 4'b0001, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 1), 0, 4'b0110, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 2), 0, 4'b1000, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 3), 0, 4'b1010, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 4), 0, 4'b0101, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 5), 0, 4'b0000, 0, 1'b0, ACT_NONE);
		push_entry(PI1_WR, ADDR_W'(RAM_BASE + 63), 0, 4'b0011, 0, 1'b0, ACT_NONE);
		for (int k = 0; k < 8; k++) begin
			push_entry(PI1_RD, ADDR_W'(RAM_BASE + k), 0, 4'hf, 0, 1'b1, ACT_NONE);
		end
		push_entry(PI1_RD, ADDR_W'(RAM_BASE + 63), 0, 4'hf, 0, 1'b1, ACT_NONE);
		push_entry(PI1_RW, ADDR_W'(RAM_BASE + 2), 0, 4'b1100, 0, 1'b1, ACT_NONE);
		push_entry(PI1_RD, ADDR_W'(RAM_BASE + 2), 0, 4'hf, 0, 1'b1, ACT_NONE);
		push_entry(PI1_RW, ADDR_W'(RAM_BASE + 6), 0, 4'hf, 0, 1'b1, ACT_NONE);
		push_entry(PI1_RD, ADDR_W'(RAM_BASE + 6), 0, 4'hf, 0, 1'b1, ACT_NONE);
		// Warm reset, a command without sel bit 0, then cold reset
		push_entry(PI1_WR, DT_RSTCTL, 32'(RST_WARM), 4'h1, 0, 1'b0, ACT_EXPECT_RST);
		push_entry(PI1_RD, DT_RSTCAUSE, 0, 4'hf, 32'(CAUSE_WARM), 1'b1, ACT_NONE);
		for (int k = 0; k < 4; k++) begin
			push_entry(PI1_RD, ADDR_W'(RAM_BASE + k), 0, 4'hf, 0, 1'b1, ACT_NONE);
		end
		push_entry(PI1_WR, DT_RSTCTL, 32'(RST_COLD), 4'b1110, 0, 1'b0, ACT_NONE);
		push_entry(PI1_RD, DT_RSTCAUSE, 0, 4'hf, 32'(CAUSE_WARM), 1'b1, ACT_NONE);
		push_entry(PI1_WR, DT_RSTCTL, 32'(RST_COLD), 4'h1, 0, 1'b0, ACT_EXPECT_RST);
		push_entry(PI1_RD, DT_RSTCAUSE, 0, 4'hf, 32'(CAUSE_COLD), 1'b1, ACT_NONE);
		for (int k = 4; k < 8; k++) begin
			push_entry(PI1_RD, ADDR_W'(RAM_BASE + k), 0, 4'hf, 0, 1'b1, ACT_NONE);
		end
		// Power-off is only left through the external reset
		push_entry(PI1_WR, DT_RSTCTL, 32'(RST_POWEROFF), 4'h1, 0, 1'b0, ACT_PULSE_RST);
		push_entry(PI1_RD, DT_RSTCAUSE, 0, 4'hf, 32'(CAUSE_POWERON), 1'b1, ACT_NONE);
		push_entry(PI1_RD, ADDR_W'(RAM_BASE + 0), 0, 4'hf, 0, 1'b1, ACT_NONE);
		push_entry(PI1_RD, ADDR_W'(RAM_BASE + 63), 0, 4'hf, 0, 1'b1, ACT_NONE);
	endtask

	initial begin
		stim_t             s;
		pi1_req_t          req;
		logic [ARCH_W-1:0] exp_data;
		logic [ARCH_W-1:0] rdata;
		logic              ok;
		logic              is_ram;
		logic              wr;
		int                idx;

		rst_p = 1'b1;
		m_req = '0;
		lcg_state = 32'h1291_f3f7;
		build_table();
		cycle_limit = stim_q.size() * 10 + 4 * 16 + 200;

		@(posedge clk_w);
		#1;
		hold_in_reset(15);
		rst_p = 1'b0;
		wait_reset_release();

		foreach (stim_q[i]) begin
			s = stim_q[i];
			req = '0;
			req.op = s.op;
			req.addr = s.addr;
			req.data = s.wdata;
			req.sel = s.sel;
			exp_data = s.exp;
			wr = (s.op == PI1_WR) || (s.op == PI1_RW);
			is_ram = (s.addr >= RAM_BASE) && (s.addr < RAM_BASE + RAM_WORDS);
			idx = is_ram ? int'(s.addr - RAM_BASE) : 0;
			if (is_ram) begin
				exp_data = ram_model[idx];
				if (wr) begin
					req.data = lcg_state;
					lcg_state = lcg_next(lcg_state);
				end
			end
			do_transfer(req, rdata, ok);
			if (ok && s.chk) begin
				check_value("m_rsp_o.data", rdata, exp_data);
			end
			if (is_ram && wr) begin
				ram_model[idx] = merge_bytes(ram_model[idx], req.data, s.sel);
			end
			case (s.act)
				ACT_EXPECT_RST: begin
					expect_reset_rise();
					wait_reset_release();
				end
				ACT_PULSE_RST: begin
					expect_reset_rise();
					hold_in_reset(40);
					rst_p = 1'b1;
					hold_in_reset(4);
					rst_p = 1'b0;
					wait_reset_release();
				end
				default: begin
				end
			endcase
		end

		$display("Errors: %0d value mismatches, %0d handshake or reset failures",
			err_cnt, fail_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
hdl/soc_pkg.sv
hdl/rst_sequencer.sv
hdl/pi1_router.sv
hdl/dev_table.sv
hdl/scratch_ram.sv
hdl/soc_top.sv
verification/soc_tb.sv

//--- Bender.yml
package:
  name: soc_bus_core

sources:
  # Package first, then the RTL bottom up
  - files:
      - hdl/soc_pkg.sv
      - hdl/rst_sequencer.sv
      - hdl/pi1_router.sv
      - hdl/dev_table.sv
      - hdl/scratch_ram.sv
      - hdl/soc_top.sv

  # Testbench, top module soc_tb
  - target: simulation
    files:
      - verification/soc_tb.sv
